//--- logic/wallacePkg.sv
// Widths and row types shared by every stage of the 8-by-8 Wallace-tree multiplier.
package wallacePkg;

  // both operands are unsigned and eight bits wide.
  localparam int operandWidth = 8;

  // every carry-save row is as wide as the full product.
  localparam int rowWidth = 16;

  // The second partial-product group (rows four to six) is compressed this many
  // columns lower and moved back up before level two.
  localparam int groupShift = 3;

  // an unsigned multiplier operand.
  typedef logic [operandWidth-1:0] operand_t;

  // a carry-save row, or the final product.
  typedef logic [rowWidth-1:0] row_t;

endpackage

//--- logic/csaRowsIf.sv
`timescale 1ns/10ps
// Bundle of the four registered carry-save rows passed from the front stage to the back stage.
interface csaRowsIf;
  import wallacePkg::*;

  // sum and carry of the first group after level two.
  row_t rowSumA;
  row_t rowCarryA;

  // sum and carry of the second group after level two.
  // these are already realigned to their true columns.
  row_t rowSumB;
  row_t rowCarryB;

  // the front stage owns the registers behind these rows.
  modport front (
    output rowSumA,
    output rowCarryA,
    output rowSumB,
    output rowCarryB
  );

  // the back stage only reads them.
  modport back (
    input rowSumA,
    input rowCarryA,
    input rowSumB,
    input rowCarryB
  );

endinterface

//--- logic/carrySaveAdder.sv
`timescale 1ns/10ps
// Row of full adders that compresses three rows into a sum row and a carry row.
module carrySaveAdder #(
  parameter int columns = 16
) (
  input  wallacePkg::row_t x,
  input  wallacePkg::row_t y,
  input  wallacePkg::row_t z,
  output wallacePkg::row_t sum,
  output wallacePkg::row_t carry
);
  import wallacePkg::*;

  // ones in the lowest columns positions, where a full adder exists.
  row_t windowMask;

  // carry of each full adder before it is moved one column up.
  row_t majority;

  assign windowMask = ~({rowWidth{1'b1}} << columns);

  // every column of the window is one full adder.
  // Columns above the window have no adder and read as zero.
  assign sum      = (x ^ y ^ z) & windowMask;
  assign majority = ((x & y) | (y & z) | (x & z)) & windowMask;

  // the carry of column i feeds column i+1 of the next level.
  // With a full 16-column window the carry of column 15 falls off the row,
  // so the caller has to show that it is always zero.
  assign carry = majority << 1;

endmodule

//--- logic/csaFrontStage.sv
`timescale 1ns/10ps
// Front pipeline stage forming partial products and running carry-save levels one and two.
module csaFrontStage (
  input  logic                 clk,
  input  logic                 rstN,
  input  wallacePkg::operand_t a,
  input  wallacePkg::operand_t b,
  csaRowsIf.front              rows
);
  import wallacePkg::*;

  // partial[i] is a gated by bit i of b and moved up to column i.
  row_t partial [operandWidth];

  // level-one rows of the first group (partial rows 0 to 2).
  row_t sumA1;
  row_t carryA1;

  // Level-one rows of the second group (partial rows 3 to 5).
  // they are groupShift columns lower than their true weight.
  row_t sumB1;
  row_t carryB1;
  row_t sumB1Aligned;
  row_t carryB1Aligned;

  // level-two rows, captured by the pipeline register.
  row_t sumA2;
  row_t carryA2;
  row_t sumB2;
  row_t carryB2;

  for (genvar i = 0; i < operandWidth; i++)
  begin : gPartial
    assign partial[i] = row_t'(a & {operandWidth{b[i]}}) << i;
  end

  // the first group spans columns 0 to 9, so a 10-column window holds it.
  carrySaveAdder #(.columns(10)) u_levelOneA (
    .x     (partial[0]),
    .y     (partial[1]),
    .z     (partial[2]),
    .sum   (sumA1),
    .carry (carryA1)
  );

  // Taken groupShift columns lower, rows 3 to 5 fit the same narrow window.
  carrySaveAdder #(.columns(10)) u_levelOneB (
    .x     (partial[3] >> groupShift),
    .y     (partial[4] >> groupShift),
    .z     (partial[5] >> groupShift),
    .sum   (sumB1),
    .carry (carryB1)
  );

  assign sumB1Aligned   = sumB1 << groupShift;
  assign carryB1Aligned = carryB1 << groupShift;

  // the last two partial rows meet the first sum. Nothing reaches column 15.
  carrySaveAdder #(.columns(15)) u_levelTwoA (
    .x     (partial[6]),
    .y     (partial[7]),
    .z     (sumA1),
    .sum   (sumA2),
    .carry (carryA2)
  );

  // the first carry meets the realigned second group, which ends at column 12.
  carrySaveAdder #(.columns(13)) u_levelTwoB (
    .x     (carryA1),
    .y     (sumB1Aligned),
    .z     (carryB1Aligned),
    .sum   (sumB2),
    .carry (carryB2)
  );

  // first pipeline register, between levels two and three.
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      rows.rowSumA   <= '0;
      rows.rowCarryA <= '0;
      rows.rowSumB   <= '0;
      rows.rowCarryB <= '0;
    end
    else
    begin
      rows.rowSumA   <= sumA2;
      rows.rowCarryA <= carryA2;
      rows.rowSumB   <= sumB2;
      rows.rowCarryB <= carryB2;
    end
  end

  // The shifted second group must stay below column 10.
  // Anything higher would be lost by the move back up or by the 13-column window.
  secondGroupFits : assert property (@(posedge clk) disable iff (!rstN)
    ((sumB1 | carryB1) >> (13 - groupShift)) == '0);

endmodule

//--- logic/csaBackStage.sv
`timescale 1ns/10ps
// Back pipeline stage running carry-save levels three and four and the second register.
module csaBackStage (
  input  logic             clk,
  input  logic             rstN,
  csaRowsIf.back           rows,
  output wallacePkg::row_t sumRow,
  output wallacePkg::row_t carryRow
);
  import wallacePkg::*;

  // level-three result of the three widest registered rows.
  row_t sum3;
  row_t carry3;

  // level-four result, the two rows left for the adder.
  row_t sum4;
  row_t carry4;

  // the three inputs stop at column 14, so 15 columns are enough.
  carrySaveAdder #(.columns(15)) u_levelThree (
    .x     (rows.rowSumA),
    .y     (rows.rowCarryA),
    .z     (rows.rowSumB),
    .sum   (sum3),
    .carry (carry3)
  );

  // the level-three carry can reach column 15, so the last level is full width.
  carrySaveAdder #(.columns(rowWidth)) u_levelFour (
    .x     (rows.rowCarryB),
    .y     (sum3),
    .z     (carry3),
    .sum   (sum4),
    .carry (carry4)
  );

  // second pipeline register, feeding the prefix adder.
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      sumRow   <= '0;
      carryRow <= '0;
    end
    else
    begin
      sumRow   <= sum4;
      carryRow <= carry4;
    end
  end

  // rows from the front stage must leave column 15 empty for the 15-column window.
  levelThreeFits : assert property (@(posedge clk) disable iff (!rstN)
    !(rows.rowSumA[rowWidth-1] | rows.rowCarryA[rowWidth-1] | rows.rowSumB[rowWidth-1]));

  // the three level-four rows must add up within 16 bits.
  // A carry out of column 15 would have no row bit to land in.
  levelFourNoOverflow : assert property (@(posedge clk) disable iff (!rstN)
    ((({2'b0, rows.rowCarryB} + {2'b0, sum3} + {2'b0, carry3}) >> rowWidth) == '0));

endmodule

//--- logic/prefixAdder.sv
`timescale 1ns/10ps
// Parallel-prefix carry-lookahead adder that turns the final sum and carry rows into the product.
module prefixAdder (
  input  wallacePkg::row_t sumRow,
  input  wallacePkg::row_t carryRow,
  output wallacePkg::row_t product
);
  import wallacePkg::*;

  // Each position holds two terms for a span of columns.
  // carry0 is the carry out of the span if no carry enters it, and carry1 the carry out if one does.
  // Position 0 is the adder's own carry-in, tied to zero.
  // Position i+1 belongs to column i.
  logic [rowWidth:0] carry0 [$clog2(rowWidth + 1) + 1];
  logic [rowWidth:0] carry1 [$clog2(rowWidth + 1) + 1];

  // carry into every column once all five levels are done
  row_t carryIn;
  logic finalCarry;

  // a column generates when both bits are set and lets a carry through when either is.
  assign carry0[0] = {sumRow & carryRow, 1'b0};
  assign carry1[0] = {sumRow | carryRow, 1'b0};

  // Each level doubles the span with the star operator.
  // After five levels the top position also covers the carry-in.
  for (genvar lvl = 0; lvl < $clog2(rowWidth + 1); lvl++)
  begin : gLevel
    for (genvar pos = 0; pos <= rowWidth; pos++)
    begin : gPos
      if (pos >= (1 << lvl))
      begin : gStar
        assign carry0[lvl+1][pos] = carry0[lvl][pos]
                                  | (carry1[lvl][pos] & carry0[lvl][pos-(1<<lvl)]);
        assign carry1[lvl+1][pos] = carry0[lvl][pos]
                                  | (carry1[lvl][pos] & carry1[lvl][pos-(1<<lvl)]);
      end
      else
      begin : gKeep
        // this span already reaches the carry-in.
        assign carry0[lvl+1][pos] = carry0[lvl][pos];
        assign carry1[lvl+1][pos] = carry1[lvl][pos];
      end
    end
  end

  // position j covers the carry-in and columns 0 to j-1, so it is the carry into column j.
  assign carryIn    = carry0[$clog2(rowWidth + 1)][rowWidth-1:0];
  assign finalCarry = carry0[$clog2(rowWidth + 1)][rowWidth];

  assign product = sumRow ^ carryRow ^ carryIn;

  // an 8-by-8 product always fits in 16 bits.
  always_comb
  begin
    assert final (finalCarry !== 1'b1)
      else $error("prefixAdder: carry out of column 15 is set");
  end

endmodule

//--- logic/wallaceMultiplier.sv
`timescale 1ns/10ps
// Top level of the two-stage pipelined 8-by-8 Wallace-tree multiplier.
module wallaceMultiplier (
  input  logic                 clk,
  input  logic                 rstN,
  input  wallacePkg::operand_t a,
  input  wallacePkg::operand_t b,
  output wallacePkg::row_t     product
);
  import wallacePkg::*;

  // registered rows between level two and level three
  csaRowsIf rowsIf ();

  // registered rows between level four and the adder.
  row_t sumRow;
  row_t carryRow;

  // Operands are taken at every rising edge.
  csaFrontStage u_frontStage (
    .clk  (clk),
    .rstN (rstN),
    .a    (a),
    .b    (b),
    .rows (rowsIf)
  );

  csaBackStage u_backStage (
    .clk      (clk),
    .rstN     (rstN),
    .rows     (rowsIf),
    .sumRow   (sumRow),
    .carryRow (carryRow)
  );

  // the product follows the second register without a further stage.
  prefixAdder u_prefixAdder (
    .sumRow   (sumRow),
    .carryRow (carryRow),
    .product  (product)
  );

endmodule

//--- tb/productChecker.sv
`timescale 1ns/10ps
// Scoreboard that predicts each product from the sampled operands and checks it after the pipeline delay.
module productChecker (
  input  logic                 clk,
  input  logic                 rstN,
  input  wallacePkg::operand_t a,
  input  wallacePkg::operand_t b,
  input  wallacePkg::row_t     refProduct,
  input  logic                 refValid,
  input  wallacePkg::row_t     product,
  output int                   errorCount,
  output int                   checkCount
);
  import wallacePkg::*;

  // rising edges, the sampling one included, that a pair takes to reach product.
  localparam int latency = 2;

  // one prediction per clean edge, oldest first.
  row_t expectQueue [$];
  row_t predicted;
  row_t expected;

  // set when the last rising edge saw rstN low.
  logic resetEdge = 1'b0;
  int   errors = 0;
  int   checks = 0;

  assign errorCount = errors;
  assign checkCount = checks;

  // inputs change on the falling edge, so they are steady here.
  always @(posedge clk)
  begin
    if (!rstN)
    begin
      // a reset edge flushes both pipeline registers, so older predictions are void.
      expectQueue.delete();
      resetEdge = 1'b1;
    end
    else
    begin
      resetEdge = 1'b0;
      predicted = row_t'(a) * row_t'(b);
      if (refValid && (refProduct !== predicted))
      begin
        $display("Table entry %0d times %0d lists %0d, which is not their product",
                 a, b, refProduct);
        errors++;
      end
      expectQueue.push_back(refValid ? refProduct : predicted);
    end
  end

  // the product is steady halfway between rising edges.
  always @(negedge clk)
  begin
    if (resetEdge)
    begin
      checks++;
      if (product !== '0)
      begin
        $display("Fail at %0d ns: product is %0d, expected %0d", $time, product, 16'd0);
        errors++;
      end
    end
    else if (expectQueue.size() >= latency)
    begin
      // the front entry was sampled one edge before the last one.
      // Both registers have taken it since, so its product is on the port now.
      expected = expectQueue.pop_front();
      checks++;
      if (product !== expected)
      begin
        $display("Fail at %0d ns: product is %0d, expected %0d", $time, product, expected);
        errors++;
      end
    end
  end

endmodule

//--- tb/tbWallaceMultiplier.sv
`timescale 1ns/10ps
// Testbench for the pipelined Wallace-tree multiplier with directed corners and xorshift traffic.
module tbWallaceMultiplier;
  import wallacePkg::*;

  localparam int resetCycles = 4;
  localparam int tableLen = 14;
  localparam int randomPairs = 200;
  localparam int margin = 10;

  // random pair that runs with rstN low.
  localparam int resetAt = 100;

  // each entry is {a, b, expected product}.
  localparam logic [31:0] directed [tableLen] = '{
    {8'd0,   8'd37,  16'd0},
    {8'd200, 8'd0,   16'd0},
    {8'd1,   8'd173, 16'd173},
    {8'd255, 8'd1,   16'd255},
    {8'd255, 8'd255, 16'd65025},
    {8'd128, 8'd128, 16'd16384},
    {8'd64,  8'd4,   16'd256},
    {8'd2,   8'd128, 16'd256},
    {8'd170, 8'd85,  16'd14450},
    {8'd85,  8'd85,  16'd7225},
    {8'd170, 8'd170, 16'd28900},
    {8'd255, 8'd128, 16'd32640},
    {8'd15,  8'd240, 16'd3600},
    {8'd240, 8'd240, 16'd57600}
  };

  logic     clk = 1'b0;
  logic     rstN;
  operand_t a;
  operand_t b;
  row_t     product;
  row_t     refProduct;
  logic     refValid;
  int       errorCount;
  int       checkCount;
  int       cycles = 0;
  int       cycleLimit;
  logic [31:0] rngState;

  wallaceMultiplier u_dut (
    .clk     (clk),
    .rstN    (rstN),
    .a       (a),
    .b       (b),
    .product (product)
  );

  productChecker u_checker (
    .clk        (clk),
    .rstN       (rstN),
    .a          (a),
    .b          (b),
    .refProduct (refProduct),
    .refValid   (refValid),
    .product    (product),
    .errorCount (errorCount),
    .checkCount (checkCount)
  );

  // 40 ns period.
  initial
  begin
    forever #20 clk = ~clk;
  end

  // 32-bit xorshift with the 13, 17, 5 shift triple.
  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // everything changes on the falling edge, half a period before sampling.
  task automatic drivePair(input operand_t nextA, input operand_t nextB, input row_t nextRef,
                           input logic nextRefValid, input logic nextRstN);
    @(negedge clk);
    a = nextA;
    b = nextB;
    refProduct = nextRef;
    refValid = nextRefValid;
    rstN = nextRstN;
  endtask

  // ends the run if the stimulus never finishes.
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("Timeout: the run did not end within %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
    end
  end

  initial
  begin
    rstN = 1'b0;
    a = '0;
    b = '0;
    refProduct = '0;
    refValid = 1'b0;
    rngState = 32'h5331;
    cycleLimit = resetCycles + tableLen + randomPairs + u_checker.latency + margin;
    repeat (resetCycles) @(negedge clk);
    rstN = 1'b1;
    // directed corners go in back to back, so two products are always in flight.
    for (int i = 0; i < tableLen; i++)
    begin
      drivePair(directed[i][31:24], directed[i][23:16], directed[i][15:0], 1'b1, 1'b1);
    end
    for (int i = 0; i < randomPairs; i++)
    begin
      rngState = xorshift(rngState);
      drivePair(rngState[7:0], rngState[15:8], '0, 1'b0, i != resetAt);
    end
    // let the last pair leave the pipeline and be checked.
    repeat (u_checker.latency + 1) @(negedge clk);
    @(posedge clk);
    $display("%0d errors in %0d checks", errorCount, checkCount);
    if (errorCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- vlog.f
logic/wallacePkg.sv
logic/csaRowsIf.sv
logic/carrySaveAdder.sv
logic/csaFrontStage.sv
logic/csaBackStage.sv
logic/prefixAdder.sv
logic/wallaceMultiplier.sv
tb/productChecker.sv
tb/tbWallaceMultiplier.sv

//--- Makefile
# Verilator build and run of the Wallace-tree multiplier testbench.

SIM = obj_dir/simWallace

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tbWallaceMultiplier \
		-f vlog.f -Mdir obj_dir -o simWallace

# the run passes only if the testbench prints the pass line.
run: compile
	out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
